//--- design/isa_pkg.sv
package isa_pkg;

    // Field widths of the 32-bit MIPS-style instruction word
    localparam int OPCODE_BITS  = 6;
    localparam int REG_BITS     = 5;
    localparam int IMM_BITS     = 16;                 // I-format immediate
    localparam int JTARGET_BITS = 26;                 // J-format word target

    // Primary opcodes used by the fetch redirect
    localparam logic [OPCODE_BITS-1:0] OPC_J   = 6'h02;  // Jump
    localparam logic [OPCODE_BITS-1:0] OPC_JAL = 6'h03;  // Jump and link
    localparam logic [OPCODE_BITS-1:0] OPC_BEQ = 6'h04;  // Branch on equal

    // $zero, both operands of the unconditional "b" form
    localparam logic [REG_BITS-1:0] REG_ZERO = '0;

    // One instruction word, seen either as I format or as J format.
    // The opcode sits in the same top bits in both views
    typedef union packed {
        struct packed {
            logic [OPCODE_BITS-1:0] opcode;           // Primary opcode
            logic [REG_BITS-1:0]    rs;               // First source reg
            logic [REG_BITS-1:0]    rt;               // Second source / target reg
            logic [IMM_BITS-1:0]    imm;              // Signed word offset for BEQ
        } i;
        struct packed {
            logic [OPCODE_BITS-1:0]  opcode;          // Primary opcode
            logic [JTARGET_BITS-1:0] target;          // Word address in 256 MB region
        } j;
    } instr_u;

endpackage

//--- design/fetch_pkg.sv
package fetch_pkg;

    // Fixed by the ISA, every instruction is one 4-byte word
    localparam int WORD_BYTES = 4;
    localparam int WORD_BITS  = WORD_BYTES * 8;       // Instruction bus width
    localparam int ALIGN_BITS = $clog2(WORD_BYTES);   // Byte offset bits, zero when aligned

    // Fetch restarts here after reset or flush
    localparam int unsigned RESET_PC = 0;

    // Read from unloaded slots, also the payload of a bubble
    localparam logic [WORD_BITS-1:0] NOP_WORD = '0;

endpackage

//--- design/program_counter.sv
`timescale 1ns/1ps

module program_counter
    import fetch_pkg::*;
#(
    parameter int PC_SIZE = 32                        // PC width in bits
)(
    input  logic               i_clk,
    input  logic               i_reset,               // Sync, active high
    input  logic               i_flush,               // Back to RESET_PC
    input  logic               i_pc_write,            // Load i_next_pc this edge
    input  logic [PC_SIZE-1:0] i_next_pc,
    output logic [PC_SIZE-1:0] o_pc
);

    logic [PC_SIZE-1:0] pc;

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            pc <= PC_SIZE'(RESET_PC);                 // Flush wins over write enable
        end else if (i_pc_write) begin
            pc <= i_next_pc;
        end
    end

    assign o_pc = pc;

    // Both the sequential adder and the redirect target must keep
    // the PC on a word boundary
    pc_word_aligned: assert property (
        @(posedge i_clk) disable iff (i_reset)
        pc[ALIGN_BITS-1:0] == '0
    ) else $error("PC left word alignment: %h", pc);

endmodule

//--- design/instruction_memory.sv
`timescale 1ns/1ps

module instruction_memory
    import fetch_pkg::*;
#(
    parameter int PC_SIZE           = 32,             // Byte address width
    parameter int MEM_SIZE_IN_WORDS = 16              // Depth in words
)(
    input  logic                 i_clk,
    input  logic                 i_reset,             // Sync, active high
    input  logic                 i_write_mem,         // Append one word
    input  logic                 i_clear_mem,         // Drop all loaded words
    input  logic [WORD_BITS-1:0] i_instruction,       // Word to append
    input  logic [PC_SIZE-1:0]   i_pc,                // Byte address to read
    output logic [WORD_BITS-1:0] o_instruction,
    output logic                 o_full_mem,
    output logic                 o_empty_mem
);

    // Slot index width with at least one bit for a single-word memory
    localparam int ADDR_BITS  = (MEM_SIZE_IN_WORDS > 1) ? $clog2(MEM_SIZE_IN_WORDS) : 1;
    // Count runs 0..MEM_SIZE_IN_WORDS inclusive
    localparam int COUNT_BITS = $clog2(MEM_SIZE_IN_WORDS + 1);
    localparam int INDEX_BITS = PC_SIZE - ALIGN_BITS;

    logic [WORD_BITS-1:0]  mem [MEM_SIZE_IN_WORDS];   // Program storage
    logic [COUNT_BITS-1:0] count;                     // Number of loaded words
    logic [INDEX_BITS-1:0] word_index;                // PC as a word address
    logic                  full;
    logic                  do_write;

    assign full     = (count == COUNT_BITS'(MEM_SIZE_IN_WORDS));
    assign do_write = i_write_mem && !full;           // Writes past the end are dropped

    // Fill counter that clear rewinds to zero
    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear_mem) begin
            count <= '0;
        end else if (do_write) begin
            count <= count + 1'b1;
        end
    end

    // Storage appended at the current count
    always_ff @(posedge i_clk) begin
        if (do_write) begin
            mem[count[ADDR_BITS-1:0]] <= i_instruction;
        end
    end

    // Drop the byte offset
    assign word_index = i_pc[PC_SIZE-1:ALIGN_BITS];

    // Combinational read where anything not yet loaded is a NOP
    always_comb begin
        if (word_index < INDEX_BITS'(count)) begin
            o_instruction = mem[word_index[ADDR_BITS-1:0]];
        end else begin
            o_instruction = NOP_WORD;
        end
    end

    assign o_full_mem  = full;
    assign o_empty_mem = (count == '0);               // Flags follow count from next cycle

    // The loader must not overlap a clear with an append because
    // the appended word would be lost without notice
    no_clear_with_write: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(i_clear_mem && i_write_mem)
    ) else $error("Memory clear and write in the same cycle");

endmodule

//--- design/if_stage.sv
`timescale 1ns/1ps

module if_stage
    import fetch_pkg::*;
#(
    parameter int PC_SIZE           = 32,             // PC width in bits
    parameter int MEM_SIZE_IN_WORDS = 16              // Instruction memory depth
)(
    input  logic                 i_clk,
    input  logic                 i_reset,             // Sync, active high
    input  logic                 i_enable,            // Run fetch
    input  logic                 i_flush,             // Restart at RESET_PC
    input  logic                 i_next_pc_src,       // 1 takes the non-sequential PC
    input  logic                 i_write_mem,         // Loader strobe
    input  logic                 i_clear_mem,         // Empty the memory
    input  logic [WORD_BITS-1:0] i_instruction,       // Word from the loader
    input  logic [PC_SIZE-1:0]   i_next_not_seq_pc,   // Redirect target
    output logic [WORD_BITS-1:0] o_instruction,       // Word at the current PC
    output logic [PC_SIZE-1:0]   o_current_pc,
    output logic [PC_SIZE-1:0]   o_next_seq_pc,       // PC + one word
    output logic                 o_full_mem,
    output logic                 o_empty_mem
);

    logic [PC_SIZE-1:0] pc;
    logic [PC_SIZE-1:0] next_pc;

    assign o_next_seq_pc = pc + PC_SIZE'(WORD_BYTES); // Sequential PC
    assign next_pc       = i_next_pc_src ? i_next_not_seq_pc : o_next_seq_pc;
    assign o_current_pc  = pc;

    program_counter #(
        .PC_SIZE    (PC_SIZE)
    ) pc_unit (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_flush    (i_flush),
        .i_pc_write (i_enable),                       // PC holds while fetch is off
        .i_next_pc  (next_pc),
        .o_pc       (pc)
    );

    instruction_memory #(
        .PC_SIZE           (PC_SIZE),
        .MEM_SIZE_IN_WORDS (MEM_SIZE_IN_WORDS)
    ) instruction_memory_unit (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_write_mem   (i_write_mem),
        .i_clear_mem   (i_clear_mem),
        .i_instruction (i_instruction),
        .i_pc          (pc),
        .o_instruction (o_instruction),
        .o_full_mem    (o_full_mem),
        .o_empty_mem   (o_empty_mem)
    );

    // Loading happens only with fetch stopped, otherwise the word
    // count could change under a running PC
    no_load_while_fetching: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(i_write_mem && i_enable)
    ) else $error("Instruction memory written while fetch enabled");

endmodule

//--- design/if_id_register.sv
`timescale 1ns/1ps

module if_id_register
    import fetch_pkg::*;
#(
    parameter int PC_SIZE = 32                        // PC width in bits
)(
    input  logic                 i_clk,
    input  logic                 i_reset,             // Sync, active high
    input  logic                 i_enable,            // Advance the pipe
    input  logic                 i_flush,             // Bubble regardless of enable
    input  logic                 i_squash,            // Drop the wrong-path word
    input  logic [WORD_BITS-1:0] i_instruction,
    input  logic [PC_SIZE-1:0]   i_pc,
    input  logic [PC_SIZE-1:0]   i_next_seq_pc,
    output logic [WORD_BITS-1:0] o_instruction,
    output logic [PC_SIZE-1:0]   o_pc,
    output logic [PC_SIZE-1:0]   o_next_seq_pc,
    output logic                 o_valid
);

    logic [WORD_BITS-1:0] instruction;
    logic [PC_SIZE-1:0]   pc;
    logic [PC_SIZE-1:0]   next_seq_pc;
    logic                 valid;

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            valid       <= 1'b0;
            instruction <= NOP_WORD;
            pc          <= '0;
            next_seq_pc <= '0;
        end else if (i_enable) begin
            if (i_squash) begin                       // Bubble, only on an advancing edge
                valid       <= 1'b0;
                instruction <= NOP_WORD;
                pc          <= '0;
                next_seq_pc <= '0;
            end else begin
                valid       <= 1'b1;                  // Every fetched word counts, NOPs too
                instruction <= i_instruction;
                pc          <= i_pc;
                next_seq_pc <= i_next_seq_pc;
            end
        end
        // Hold otherwise
    end

    assign o_instruction = instruction;
    assign o_pc          = pc;
    assign o_next_seq_pc = next_seq_pc;
    assign o_valid       = valid;

endmodule

//--- design/fetch_redirect.sv
`timescale 1ns/1ps

module fetch_redirect
    import isa_pkg::*;
    import fetch_pkg::*;
#(
    parameter int PC_SIZE = 32                        // At least 28 for the J region
)(
    input  logic               i_valid,               // IF/ID holds a real word
    input  instr_u             i_instruction,         // IF/ID word
    input  logic [PC_SIZE-1:0] i_next_seq_pc,         // IF/ID PC + one word
    output logic               o_redirect,            // Take o_target next edge
    output logic [PC_SIZE-1:0] o_target
);

    // Low PC bits replaced by a J-format target
    localparam int JREGION_BITS = JTARGET_BITS + ALIGN_BITS;

    logic               is_jump;                      // J or JAL
    logic               is_uncond_branch;             // BEQ $zero, $zero
    logic [PC_SIZE-1:0] region_mask;
    logic [PC_SIZE-1:0] jump_target;
    logic [PC_SIZE-1:0] branch_offset;
    logic [PC_SIZE-1:0] branch_target;

    assign is_jump = (i_instruction.j.opcode == OPC_J) ||
                     (i_instruction.j.opcode == OPC_JAL);

    // Register compare is trivially true only for $zero against $zero
    assign is_uncond_branch = (i_instruction.i.opcode == OPC_BEQ) &&
                              (i_instruction.i.rs == REG_ZERO) &&
                              (i_instruction.i.rt == REG_ZERO);

    assign o_redirect = i_valid && (is_jump || is_uncond_branch);  // Bubbles never redirect

    // Keep the region bits of PC+4, replace the rest
    assign region_mask = PC_SIZE'({JREGION_BITS{1'b1}});
    assign jump_target = (i_next_seq_pc & ~region_mask) |
                         PC_SIZE'({i_instruction.j.target, {ALIGN_BITS{1'b0}}});

    // Sign-extended word offset, relative to PC+4
    assign branch_offset = {{(PC_SIZE-IMM_BITS-ALIGN_BITS){i_instruction.i.imm[IMM_BITS-1]}},
                            i_instruction.i.imm, {ALIGN_BITS{1'b0}}};
    assign branch_target = i_next_seq_pc + branch_offset;

    assign o_target = is_uncond_branch ? branch_target : jump_target;

    // An aligned target relies on an aligned IF/ID PC coming from fetch
    always_comb begin
        redirect_target_aligned: assert final (
            !o_redirect || (o_target[ALIGN_BITS-1:0] == '0)
        ) else $error("Redirect to unaligned target %h", o_target);
    end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter int PC_SIZE           = 32,             // PC width, 28 or more
    parameter int MEM_SIZE_IN_WORDS = 16              // Instruction memory depth
)(
    input  logic                 i_clk,
    input  logic                 i_reset,             // Sync, active high
    input  logic                 i_enable,            // Run fetch
    input  logic                 i_write_mem,         // Loader strobe, fetch off only
    input  logic [WORD_BITS-1:0] i_instruction,       // Loader word
    input  logic                 i_clear_mem,         // Empty the memory
    input  logic                 i_flush,             // Restart at RESET_PC
    output logic                 o_full_mem,
    output logic                 o_empty_mem,
    output logic [WORD_BITS-1:0] o_id_instruction,    // IF/ID contents
    output logic [PC_SIZE-1:0]   o_id_pc,
    output logic                 o_id_valid
);

    // Fetch to IF/ID
    logic [WORD_BITS-1:0] if_instruction;
    logic [PC_SIZE-1:0]   if_pc;
    logic [PC_SIZE-1:0]   if_next_seq_pc;

    // IF/ID to redirect
    logic [PC_SIZE-1:0]   id_next_seq_pc;

    // Redirect back to fetch
    logic                 redirect;
    logic [PC_SIZE-1:0]   redirect_target;

    if_stage #(
        .PC_SIZE           (PC_SIZE),
        .MEM_SIZE_IN_WORDS (MEM_SIZE_IN_WORDS)
    ) if_stage_unit (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_enable          (i_enable),
        .i_flush           (i_flush),
        .i_next_pc_src     (redirect),
        .i_write_mem       (i_write_mem),
        .i_clear_mem       (i_clear_mem),
        .i_instruction     (i_instruction),
        .i_next_not_seq_pc (redirect_target),
        .o_instruction     (if_instruction),
        .o_current_pc      (if_pc),
        .o_next_seq_pc     (if_next_seq_pc),
        .o_full_mem        (o_full_mem),
        .o_empty_mem       (o_empty_mem)
    );

    if_id_register #(
        .PC_SIZE       (PC_SIZE)
    ) if_id_unit (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_enable      (i_enable),
        .i_flush       (i_flush),
        .i_squash      (redirect),                    // Wrong-path word becomes a bubble
        .i_instruction (if_instruction),
        .i_pc          (if_pc),
        .i_next_seq_pc (if_next_seq_pc),
        .o_instruction (o_id_instruction),
        .o_pc          (o_id_pc),
        .o_next_seq_pc (id_next_seq_pc),
        .o_valid       (o_id_valid)
    );

    fetch_redirect #(
        .PC_SIZE       (PC_SIZE)
    ) redirect_unit (
        .i_valid       (o_id_valid),
        .i_instruction (o_id_instruction),
        .i_next_seq_pc (id_next_seq_pc),
        .o_redirect    (redirect),
        .o_target      (redirect_target)
    );

endmodule

//--- tests/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top
    import isa_pkg::*;
    import fetch_pkg::*;
();

    localparam int PC_SIZE           = 32;
    localparam int MEM_SIZE_IN_WORDS = 16;
    localparam int CLK_PERIOD        = 4;                       // ns
    localparam int RESET_CYCLES      = 3;
    localparam int RUN_SEQ           = MEM_SIZE_IN_WORDS + 4;   // Runs past the count into NOPs
    localparam int RUN_JUMP          = 32;
    // Cycle budget per test where loads cost one cycle per word
    localparam int TEST_CYCLES = (RESET_CYCLES + MEM_SIZE_IN_WORDS + 8)
                               + (RUN_SEQ + 4)
                               + (MEM_SIZE_IN_WORDS + RUN_JUMP + 10)
                               + 24
                               + 24;
    localparam int MARGIN_CYCLES = 50;

    logic                 i_clk;
    logic                 i_reset;
    logic                 i_enable;
    logic                 i_write_mem;
    logic [WORD_BITS-1:0] i_instruction;
    logic                 i_clear_mem;
    logic                 i_flush;
    logic                 o_full_mem;
    logic                 o_empty_mem;
    logic [WORD_BITS-1:0] o_id_instruction;
    logic [PC_SIZE-1:0]   o_id_pc;
    logic                 o_id_valid;

    // Reference model state
    logic [WORD_BITS-1:0] model_mem [MEM_SIZE_IN_WORDS];
    int                   model_count;                  // Loaded words
    logic [PC_SIZE-1:0]   model_pc;
    logic [WORD_BITS-1:0] exp_word;                     // Expected IF/ID entry
    logic [PC_SIZE-1:0]   exp_pc;
    logic                 exp_valid;
    logic                 model_ready;                  // Set after the first reset edge

    int                   error_count;
    int                   check_count;
    int                   errors_before;                // Error count at test start
    logic [31:0]          rng_state;

    fetch_top #(
        .PC_SIZE           (PC_SIZE),
        .MEM_SIZE_IN_WORDS (MEM_SIZE_IN_WORDS)
    ) dut0 (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_enable         (i_enable),
        .i_write_mem      (i_write_mem),
        .i_instruction    (i_instruction),
        .i_clear_mem      (i_clear_mem),
        .i_flush          (i_flush),
        .o_full_mem       (o_full_mem),
        .o_empty_mem      (o_empty_mem),
        .o_id_instruction (o_id_instruction),
        .o_id_pc          (o_id_pc),
        .o_id_valid       (o_id_valid)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s expected %h got %h at %0d ns", name, expected, actual, $time);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Random word that never redirects
    function automatic logic [31:0] random_filler();
        instr_u w;
        rng_state = xorshift32(rng_state);
        w         = rng_state;
        if (w.i.opcode inside {OPC_J, OPC_JAL, OPC_BEQ}) begin
            w.i.opcode = w.i.opcode ^ 6'h20;                    // Into the load opcodes
        end
        return w;
    endfunction

    function automatic logic [31:0] jump_word(input logic [5:0] opcode, input int word_index);
        instr_u w;
        w.j.opcode = opcode;
        w.j.target = JTARGET_BITS'(word_index);                 // Target counts words
        return w;
    endfunction

    // BEQ on $zero against $zero as the "b" form
    function automatic logic [31:0] branch_word(input int word_offset);
        instr_u w;
        w.i.opcode = OPC_BEQ;
        w.i.rs     = '0;
        w.i.rt     = '0;
        w.i.imm    = IMM_BITS'(word_offset);
        return w;
    endfunction

    // Redirect decision and target for an IF/ID entry
    function automatic logic model_redirect(input logic [31:0] word, input logic valid,
                                            input logic [31:0] id_pc,
                                            output logic [31:0] target);
        instr_u      w;
        logic [31:0] seq_pc;
        logic [31:0] offset;
        w      = word;
        seq_pc = id_pc + WORD_BYTES;
        offset = {{14{w.i.imm[15]}}, w.i.imm, 2'b00};          // Sign-extended times four
        target = '0;
        if (!valid) begin
            return 1'b0;                                        // Bubbles never redirect
        end
        if (w.j.opcode == OPC_J || w.j.opcode == OPC_JAL) begin
            target = {seq_pc[31:28], w.j.target, 2'b00};
            return 1'b1;
        end
        if (w.i.opcode == OPC_BEQ && w.i.rs == 5'd0 && w.i.rt == 5'd0) begin
            target = seq_pc + offset;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] pc);
        logic [31:0] index;
        index = pc / WORD_BYTES;
        if (index < model_count) begin
            return model_mem[index];
        end
        return NOP_WORD;                                        // Unloaded slot
    endfunction

    // One clock edge of the fetch path leaving the expected IF/ID entry
    function automatic void ref_fetch(input logic rst, input logic en, input logic fl);
        logic        redirect;
        logic [31:0] target;
        redirect = model_redirect(exp_word, exp_valid, exp_pc, target);
        if (rst || fl) begin
            model_pc  = RESET_PC;
            exp_valid = 1'b0;
            exp_word  = NOP_WORD;
            exp_pc    = '0;
        end else if (en) begin
            if (redirect) begin
                exp_valid = 1'b0;                               // Wrong-path word dropped
                exp_word  = NOP_WORD;
                exp_pc    = '0;
            end else begin
                exp_valid = 1'b1;
                exp_word  = model_read(model_pc);
                exp_pc    = model_pc;
            end
            model_pc = redirect ? target : model_pc + WORD_BYTES;
        end
    endfunction

    // One clock edge of the loader
    function automatic void ref_load(input logic rst, input logic clr, input logic wr,
                                     input logic [31:0] word);
        if (rst || clr) begin
            model_count = 0;
        end else if (wr && model_count < MEM_SIZE_IN_WORDS) begin
            model_mem[model_count] = word;                      // Writes while full ignored
            model_count++;
        end
    endfunction

    // Outputs seen here are the ones settled since the last edge
    always @(posedge i_clk) begin
        if (model_ready) begin
            check_value("o_id_valid", exp_valid, o_id_valid);
            check_value("o_id_instruction", exp_word, o_id_instruction);
            if (exp_valid) begin
                check_value("o_id_pc", exp_pc, o_id_pc);
            end
            check_value("o_empty_mem", model_count == 0, o_empty_mem);
            check_value("o_full_mem", model_count == MEM_SIZE_IN_WORDS, o_full_mem);
        end
        ref_fetch(i_reset, i_enable, i_flush);
        ref_load(i_reset, i_clear_mem, i_write_mem, i_instruction);
        if (i_reset) begin
            model_ready = 1'b1;
        end
    end

    task automatic begin_test();
        errors_before = error_count;
    endtask

    task automatic end_test(input int number, input string name);
        if (error_count == errors_before) begin
            $display("Test %0d %s: ok", number, name);
        end else begin
            $display("Test %0d %s: %0d mismatches", number, name, error_count - errors_before);
        end
    endtask

    // One word per cycle with fetch stopped
    task automatic load_words(input logic [31:0] words[$]);
        foreach (words[k]) begin
            @(negedge i_clk);
            i_write_mem   = 1'b1;
            i_instruction = words[k];
        end
        @(negedge i_clk);
        i_write_mem = 1'b0;
    endtask

    task automatic run_fetch(input int cycles);
        @(negedge i_clk);
        i_enable = 1'b1;
        repeat (cycles) @(negedge i_clk);
        i_enable = 1'b0;
    endtask

    task automatic pulse_flush();
        @(negedge i_clk);
        i_flush = 1'b1;
        @(negedge i_clk);
        i_flush = 1'b0;
    endtask

    task automatic pulse_clear();
        @(negedge i_clk);
        i_clear_mem = 1'b1;
        @(negedge i_clk);
        i_clear_mem = 1'b0;
    endtask

    initial begin
        logic [31:0] program_words[$];
        logic [31:0] held_word;
        logic [31:0] held_pc;
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_enable      = 1'b0;
        i_write_mem   = 1'b0;
        i_instruction = '0;
        i_clear_mem   = 1'b0;
        i_flush       = 1'b0;
        rng_state     = 32'hb390;
        error_count   = 0;
        check_count   = 0;
        model_ready   = 1'b0;
        model_count   = 0;
        model_pc      = '0;
        exp_word      = NOP_WORD;
        exp_pc        = '0;
        exp_valid     = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_reset = 1'b0;

        // Flags through a full load and one write too many
        begin_test();
        check_value("o_empty_mem", 1, o_empty_mem);
        check_value("o_full_mem", 0, o_full_mem);
        check_value("o_id_valid", 0, o_id_valid);
        repeat (MEM_SIZE_IN_WORDS) program_words.push_back(random_filler());
        load_words(program_words);
        check_value("o_full_mem", 1, o_full_mem);
        check_value("o_empty_mem", 0, o_empty_mem);
        program_words.delete();
        program_words.push_back(32'h2400_ffff);               // Must be dropped
        load_words(program_words);
        check_value("o_full_mem", 1, o_full_mem);
        end_test(1, "load and flags");

        // Straight-line fetch running past the count
        begin_test();
        run_fetch(RUN_SEQ);
        check_value("o_id_valid", 1, o_id_valid);
        check_value("o_id_instruction", NOP_WORD, o_id_instruction);
        check_value("o_id_pc", (RUN_SEQ - 1) * WORD_BYTES, o_id_pc);
        end_test(2, "sequential fetch");

        // J to word 6, JAL to word 10, b to word 13, then a b loop on 13 and 14
        begin_test();
        pulse_clear();
        program_words.delete();
        for (int k = 0; k < MEM_SIZE_IN_WORDS; k++) begin
            program_words.push_back(random_filler());
        end
        program_words[1]  = jump_word(OPC_J, 6);
        program_words[7]  = jump_word(OPC_JAL, 10);
        program_words[10] = branch_word(2);                     // PC+4 is word 11
        program_words[14] = branch_word(-2);                    // Backward offset needs sign extension
        load_words(program_words);
        pulse_flush();
        run_fetch(RUN_JUMP);
        end_test(3, "jumps and branches");

        // Stop with the J sitting in IF/ID and its redirect pending
        begin_test();
        pulse_flush();
        run_fetch(2);
        held_word = jump_word(OPC_J, 6);                        // J fetched from word 1
        held_pc   = WORD_BYTES;
        check_value("o_id_instruction", held_word, o_id_instruction);
        check_value("o_id_pc", held_pc, o_id_pc);
        repeat (3) begin
            @(negedge i_clk);
            check_value("o_id_instruction", held_word, o_id_instruction);
            check_value("o_id_pc", held_pc, o_id_pc);
        end
        run_fetch(10);
        end_test(4, "hold and resume");

        // Flush while running and then fetch from an emptied memory
        begin_test();
        @(negedge i_clk);
        i_enable = 1'b1;
        repeat (4) @(negedge i_clk);
        i_flush = 1'b1;
        @(negedge i_clk);
        i_flush = 1'b0;
        check_value("o_id_valid", 0, o_id_valid);               // Bubble first
        check_value("o_id_instruction", NOP_WORD, o_id_instruction);
        @(negedge i_clk);
        i_enable = 1'b0;
        check_value("o_id_valid", 1, o_id_valid);
        check_value("o_id_pc", RESET_PC, o_id_pc);
        pulse_clear();
        check_value("o_empty_mem", 1, o_empty_mem);
        check_value("o_full_mem", 0, o_full_mem);
        pulse_flush();
        run_fetch(4);
        check_value("o_id_valid", 1, o_id_valid);
        check_value("o_id_instruction", NOP_WORD, o_id_instruction);
        end_test(5, "flush and clear");

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Ends a stuck run
    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("Timeout: run did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- build.f
design/isa_pkg.sv
design/fetch_pkg.sv
design/program_counter.sv
design/instruction_memory.sv
design/if_stage.sv
design/if_id_register.sv
design/fetch_redirect.sv
design/fetch_top.sv
tests/tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_top

sources:
  - design/isa_pkg.sv
  - design/fetch_pkg.sv
  - design/program_counter.sv
  - design/instruction_memory.sv
  - design/if_stage.sv
  - design/if_id_register.sv
  - design/fetch_redirect.sv
  - design/fetch_top.sv
  - target: test
    files:
      - tests/tb_fetch_top.sv
